//--- design/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ============================================================
// fetch buffer build constants
// ============================================================

// lines held in the prefetch queue, power of two
`define FB_DEPTH 4

// bits in one instruction cache line
`define FB_LINE_BITS 128

// first fetch address after reset
`define FB_RESET_PC 32'h80000000

`endif

//--- design/fetch_types_pkg.sv
`include "fetch_defines.svh"

package fetch_types_pkg;

  // byte offset bits inside one line
  localparam int unsigned OFFSET_BITS = $clog2(`FB_LINE_BITS / 8);

  // byte address on the core and cache side
  typedef logic [31:0] addr_t;

  // line number, address without the offset bits
  typedef logic [31-OFFSET_BITS:0] tag_t;

  // one full cache line
  typedef logic [`FB_LINE_BITS-1:0] line_t;

  // one 32-bit instruction word
  typedef logic [31:0] inst_t;

endpackage

//--- design/bus_types_pkg.sv
package bus_types_pkg;

  // read response code, anything but okay is an error
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // line fill FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT_RESP,
    DRAIN
  } fill_state_e;

endpackage

//--- design/line_fill_ctrl.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module line_fill_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   jmp_flush_i,
  input  fetch_types_pkg::addr_t pc_i,
  input  logic                   queue_full_i,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output fetch_types_pkg::addr_t ar_addr_o,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  fetch_types_pkg::line_t r_data_i,
  input  bus_types_pkg::resp_t   r_resp_i,
  output logic                   push_o,
  output fetch_types_pkg::tag_t  push_tag_o,
  output fetch_types_pkg::line_t push_line_o,
  output logic                   push_err_o
);
  import fetch_types_pkg::*;
  import bus_types_pkg::*;

  localparam addr_t RESET_PC = `FB_RESET_PC;

  fill_state_e state_q;
  fill_state_e state_d;
  tag_t        next_tag_q;
  tag_t        next_tag_d;
  tag_t        req_tag_q;
  tag_t        pc_tag;
  logic        ar_valid_q;
  logic        ar_valid_d;
  logic        ar_fire;
  logic        r_fire;

  assign pc_tag  = pc_i[31:OFFSET_BITS];
  assign ar_fire = ar_valid_q & ar_ready_i;
  assign r_fire  = r_valid_i & r_ready_o;

  // ============================================================
  // fill FSM
  // ============================================================

  always_comb begin
    state_d    = state_q;
    next_tag_d = next_tag_q;
    ar_valid_d = ar_valid_q;
    case (state_q)
      IDLE: begin
        if (ar_fire) begin
          ar_valid_d = 1'b0;
          next_tag_d = next_tag_q + 1'b1;
          // a request taken on the flush edge is already stale
          state_d    = jmp_flush_i ? DRAIN : WAIT_RESP;
        end else if (!ar_valid_q && !queue_full_i) begin
          ar_valid_d = 1'b1;
        end
      end
      WAIT_RESP: begin
        if (r_fire) begin
          state_d = IDLE;
        end else if (jmp_flush_i) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // swallow the old response, then refetch
        if (r_fire) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // jump restarts the stream at the new pc
    if (jmp_flush_i) begin
      next_tag_d = pc_tag;
      ar_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q    <= IDLE;
      ar_valid_q <= 1'b0;
      next_tag_q <= RESET_PC[31:OFFSET_BITS];
    end else begin
      state_q    <= state_d;
      ar_valid_q <= ar_valid_d;
      next_tag_q <= next_tag_d;
    end
  end

  // tag of the line on its way back
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      req_tag_q <= next_tag_q;
    end
  end

  // ============================================================
  // bus and queue outputs
  // ============================================================

  assign ar_valid_o = ar_valid_q;
  assign ar_addr_o  = {next_tag_q, {OFFSET_BITS{1'b0}}};
  assign r_ready_o  = (state_q == WAIT_RESP) || (state_q == DRAIN);

  // no push for a line that lands on a flush edge
  assign push_o      = r_fire && (state_q == WAIT_RESP) && !jmp_flush_i;
  assign push_tag_o  = req_tag_q;
  assign push_line_o = r_data_i;
  assign push_err_o  = (r_resp_i != RESP_OKAY);

endmodule

//--- design/line_queue.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module line_queue #(
  parameter int unsigned DEPTH = `FB_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic                   push_i,
  input  fetch_types_pkg::tag_t  push_tag_i,
  input  fetch_types_pkg::line_t push_line_i,
  input  logic                   push_err_i,
  input  logic                   inflight_i,
  input  logic                   pop_i,
  output logic                   full_o,
  output logic                   head_valid_o,
  output fetch_types_pkg::tag_t  head_tag_o,
  output fetch_types_pkg::line_t head_line_o,
  output logic                   head_err_o
);
  import fetch_types_pkg::*;

  localparam int unsigned PTR_W = $clog2(DEPTH);

  // pointers carry one extra wrap bit
  logic [PTR_W:0]   wr_ptr_q;
  logic [PTR_W:0]   rd_ptr_q;
  logic [PTR_W:0]   count;
  logic [PTR_W+1:0] occupancy;
  logic [PTR_W-1:0] rd_idx;
  logic [PTR_W-1:0] wr_idx;
  logic             empty;
  logic             mem_full;
  logic             push_en;
  logic             pop_en;

  tag_t  tag_mem  [DEPTH];
  line_t line_mem [DEPTH];
  logic  err_mem  [DEPTH];

  assign rd_idx   = rd_ptr_q[PTR_W-1:0];
  assign wr_idx   = wr_ptr_q[PTR_W-1:0];
  assign empty    = (wr_ptr_q == rd_ptr_q);
  assign mem_full = (wr_ptr_q == {~rd_ptr_q[PTR_W], rd_ptr_q[PTR_W-1:0]});
  assign push_en  = push_i & ~mem_full;
  assign pop_en   = pop_i & ~empty;

  // ============================================================
  // occupancy, the line in flight reserves a slot
  // ============================================================

  assign count     = wr_ptr_q - rd_ptr_q;
  assign occupancy = {1'b0, count} + {{(PTR_W+1){1'b0}}, inflight_i};
  assign full_o    = (occupancy >= DEPTH);

  // pointer update, flush drops every entry
  always_ff @(posedge clk) begin
    if (rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (push_en) begin
      tag_mem[wr_idx]  <= push_tag_i;
      line_mem[wr_idx] <= push_line_i;
      err_mem[wr_idx]  <= push_err_i;
    end
  end

  // head of queue
  assign head_valid_o = ~empty;
  assign head_tag_o   = tag_mem[rd_idx];
  assign head_line_o  = line_mem[rd_idx];
  assign head_err_o   = err_mem[rd_idx];

endmodule

//--- design/inst_select.sv
`timescale 1ns/1ps

module inst_select (
  input  fetch_types_pkg::addr_t pc_i,
  input  logic                   head_valid_i,
  input  fetch_types_pkg::tag_t  head_tag_i,
  input  fetch_types_pkg::line_t head_line_i,
  input  logic                   head_err_i,
  input  logic                   byp_valid_i,
  input  fetch_types_pkg::tag_t  byp_tag_i,
  input  fetch_types_pkg::line_t byp_line_i,
  input  logic                   byp_err_i,
  output logic                   pop_o,
  output logic                   inst_valid_o,
  output fetch_types_pkg::inst_t inst_o,
  output logic                   inst_err_o
);
  import fetch_types_pkg::*;

  tag_t       pc_tag;
  logic [1:0] word_sel;
  logic       head_hit;
  logic       byp_hit;
  line_t      sel_line;
  logic       sel_err;

  assign pc_tag   = pc_i[31:OFFSET_BITS];
  assign word_sel = pc_i[3:2];

  // ============================================================
  // tag match
  // ============================================================

  assign head_hit = head_valid_i && (head_tag_i == pc_tag);

  // bypass only counts while the queue is empty
  assign byp_hit  = !head_valid_i && byp_valid_i && (byp_tag_i == pc_tag);

  // pc has left the head line, retire it
  assign pop_o = head_valid_i && (head_tag_i != pc_tag);

  // ============================================================
  // word pick
  // ============================================================

  always_comb begin
    if (head_valid_i) begin
      sel_line = head_line_i;
      sel_err  = head_err_i;
    end else begin
      sel_line = byp_line_i;
      sel_err  = byp_err_i;
    end
  end

  assign inst_o       = sel_line[{word_sel, 5'b00000} +: 32];
  assign inst_valid_o = head_hit | byp_hit;
  // error follows the line the word came from
  assign inst_err_o   = inst_valid_o & sel_err;

endmodule

//--- design/fetch_buffer_top.sv
`timescale 1ns/1ps

module fetch_buffer_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // cache read address channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output fetch_types_pkg::addr_t ar_addr_o,
  // cache read data channel
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  fetch_types_pkg::line_t r_data_i,
  input  bus_types_pkg::resp_t   r_resp_i,
  // core side
  input  fetch_types_pkg::addr_t pc_i,
  input  logic                   jmp_flush_i,
  output logic                   inst_valid_o,
  output fetch_types_pkg::inst_t inst_o,
  output logic                   inst_err_o
);
  import fetch_types_pkg::*;

  logic  push;
  tag_t  push_tag;
  line_t push_line;
  logic  push_err;
  logic  queue_full;
  logic  head_valid;
  tag_t  head_tag;
  line_t head_line;
  logic  head_err;
  logic  pop;

  line_fill_ctrl u_fill (
    .clk          (clk),
    .rst_n        (rst_n),
    .jmp_flush_i  (jmp_flush_i),
    .pc_i         (pc_i),
    .queue_full_i (queue_full),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .push_o       (push),
    .push_tag_o   (push_tag),
    .push_line_o  (push_line),
    .push_err_o   (push_err)
  );

  // r_ready_o is high exactly while a line is in flight
  line_queue u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (jmp_flush_i),
    .push_i       (push),
    .push_tag_i   (push_tag),
    .push_line_i  (push_line),
    .push_err_i   (push_err),
    .inflight_i   (r_ready_o),
    .pop_i        (pop),
    .full_o       (queue_full),
    .head_valid_o (head_valid),
    .head_tag_o   (head_tag),
    .head_line_o  (head_line),
    .head_err_o   (head_err)
  );

  inst_select u_select (
    .pc_i         (pc_i),
    .head_valid_i (head_valid),
    .head_tag_i   (head_tag),
    .head_line_i  (head_line),
    .head_err_i   (head_err),
    .byp_valid_i  (push),
    .byp_tag_i    (push_tag),
    .byp_line_i   (push_line),
    .byp_err_i    (push_err),
    .pop_o        (pop),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .inst_err_o   (inst_err_o)
  );

endmodule

//--- tb/icache_model.sv
`timescale 1ns/1ps

module icache_model #(
  parameter logic [15:0] SEED = 16'd33998
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  fetch_types_pkg::addr_t ar_addr_i,
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output fetch_types_pkg::line_t r_data_o,
  output bus_types_pkg::resp_t   r_resp_o,
  input  fetch_types_pkg::addr_t err_line_i
);
  import fetch_types_pkg::*;
  import bus_types_pkg::*;

  logic [15:0] lfsr_q;
  logic        rst_s;
  logic        ar_hs;
  logic        r_hs;
  addr_t       addr_s;
  logic        pend;
  addr_t       pend_addr;
  int unsigned a_wait;
  int unsigned r_wait;

  // galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // stall of 0 to 3 cycles, one LFSR step per bit
  task automatic draw_stall(output int unsigned n);
    n = 0;
    repeat (2) begin
      n      = {n[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // word k of the line at a holds (a + 4k) ^ 5A5A5A5A
  function automatic line_t line_data(input addr_t a);
    line_t l;
    for (int k = 0; k < 4; k++) begin
      l[32*k +: 32] = (a + 4 * k) ^ 32'h5A5A5A5A;
    end
    return l;
  endfunction

  initial begin
    lfsr_q     = SEED;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_resp_o   = RESP_OKAY;
    pend       = 1'b0;
    a_wait     = 0;
    r_wait     = 0;
    forever begin
      // sample at the falling edge, drive just after the rising one
      @(negedge clk);
      rst_s  = rst_n;
      ar_hs  = ar_valid_i && ar_ready_o;
      r_hs   = r_valid_o && r_ready_i;
      addr_s = ar_addr_i;
      @(posedge clk);
      #1;
      if (rst_s) begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        pend       = 1'b0;
        draw_stall(a_wait);
      end else begin
        if (r_hs) begin
          r_valid_o = 1'b0;
        end
        if (ar_hs) begin
          ar_ready_o = 1'b0;
          pend       = 1'b1;
          pend_addr  = addr_s;
          draw_stall(r_wait);
          draw_stall(a_wait);
        end else if (pend && !r_valid_o) begin
          if (r_wait == 0) begin
            r_valid_o = 1'b1;
            r_data_o  = line_data(pend_addr);
            r_resp_o  = (pend_addr[31:4] == err_line_i[31:4]) ? 2'd2 : RESP_OKAY;
            pend      = 1'b0;
          end else begin
            r_wait--;
          end
        end
        if (ar_valid_i && !ar_ready_o && !ar_hs) begin
          if (a_wait == 0) begin
            ar_ready_o = 1'b1;
          end else begin
            a_wait--;
          end
        end
      end
    end
  end

endmodule

//--- tb/tb_fetch_buffer.sv
`timescale 1ns/1ps
`include "fetch_defines.svh"

module tb_fetch_buffer;
  import fetch_types_pkg::*;
  import bus_types_pkg::*;

  localparam addr_t       RESET_PC   = `FB_RESET_PC;
  localparam int unsigned DEPTH      = `FB_DEPTH;
  localparam addr_t       LIMIT_PC   = 32'h80001000;
  localparam addr_t       JUMP_PC    = 32'h80002008;
  localparam addr_t       ERR_LINE   = 32'h80003000;
  // about 35 lines at up to 12 cycles, 90 word steps and a 40 cycle window, wide margin
  localparam int unsigned MAX_CYCLES = 4000;

  logic  clk;
  logic  rst_n;
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;
  logic  r_valid;
  logic  r_ready;
  line_t r_data;
  resp_t r_resp;
  addr_t pc;
  logic  jmp_flush;
  logic  inst_valid;
  inst_t inst;
  logic  inst_err;
  addr_t err_line;

  int unsigned error_cnt;
  int unsigned check_cnt;
  int unsigned test_cnt;
  int unsigned cycle_cnt;
  addr_t       req_log[$];

  fetch_buffer_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .ar_valid_o   (ar_valid),
    .ar_ready_i   (ar_ready),
    .ar_addr_o    (ar_addr),
    .r_valid_i    (r_valid),
    .r_ready_o    (r_ready),
    .r_data_i     (r_data),
    .r_resp_i     (r_resp),
    .pc_i         (pc),
    .jmp_flush_i  (jmp_flush),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_err_o   (inst_err)
  );

  icache_model #(.SEED(16'd33998)) u_cache (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_resp_o   (r_resp),
    .err_line_i (err_line)
  );

  always #2 clk = ~clk;

  // log of accepted line requests
  always @(negedge clk) begin
    if (ar_valid && ar_ready) begin
      req_log.push_back(ar_addr);
    end
  end

  // ============================================================
  // helpers
  // ============================================================

  function automatic inst_t expect_word(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5A5A5A5A;
  endfunction

  task automatic report_mismatch(input string name, input addr_t at,
                                 input logic [31:0] got, input logic [31:0] exp);
    $display("** Error: %s at pc %h: got %h, expected %h", name, at, got, exp);
    error_cnt++;
  endtask

  task automatic finish_test(input string name, input int unsigned err0);
    test_cnt++;
    $display("test %-22s %0d errors", name, error_cnt - err0);
  endtask

  task automatic wait_requests(input int unsigned n);
    while (req_log.size() < n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic jump_to(input addr_t target);
    pc        = target;
    jmp_flush = 1'b1;
    @(posedge clk);
    #1;
    jmp_flush = 1'b0;
    req_log.delete();
  endtask

  // present pc, wait for a valid word and check it
  task automatic fetch_check(input addr_t a, input logic exp_err);
    pc = a;
    @(negedge clk);
    while (!inst_valid) @(negedge clk);
    check_cnt += 2;
    if (inst !== expect_word(a)) report_mismatch("inst_o", a, inst, expect_word(a));
    if (inst_err !== exp_err) report_mismatch("inst_err_o", a, {31'b0, inst_err}, {31'b0, exp_err});
    @(posedge clk);
    #1;
  endtask

  // ============================================================
  // tests
  // ============================================================

  task automatic test_reset_first_fetch();
    int unsigned err0;
    err0 = error_cnt;
    repeat (2) @(posedge clk);
    #1;
    check_cnt++;
    if ({ar_valid, r_ready, inst_valid, inst_err} !== 4'b0000) begin
      report_mismatch("{ar_valid_o,r_ready_o,inst_valid_o,inst_err_o}", pc,
                      {28'b0, ar_valid, r_ready, inst_valid, inst_err}, 32'h0);
    end
    rst_n = 1'b0;
    wait_requests(1);
    check_cnt++;
    if (req_log[0] !== RESET_PC) report_mismatch("ar_addr_o", pc, req_log[0], RESET_PC);
    finish_test("reset_first_fetch", err0);
  endtask

  task automatic test_sequential_stream();
    int unsigned err0;
    err0 = error_cnt;
    for (int i = 0; i < 64; i++) begin
      fetch_check(RESET_PC + 4 * i, 1'b0);
    end
    finish_test("sequential_stream", err0);
  endtask

  task automatic test_prefetch_limit();
    int unsigned err0;
    err0 = error_cnt;
    jump_to(LIMIT_PC);
    wait_requests(DEPTH);
    // pc held, the queue has to stop asking
    repeat (40) @(posedge clk);
    #1;
    check_cnt++;
    if (req_log.size() > DEPTH) begin
      $display("error: %0d line requests accepted with pc held, queue holds only %0d",
               req_log.size(), DEPTH);
      error_cnt++;
    end
    for (int i = 0; i < req_log.size(); i++) begin
      check_cnt++;
      if (req_log[i] !== LIMIT_PC + 16 * i) begin
        report_mismatch("ar_addr_o", pc, req_log[i], LIMIT_PC + 16 * i);
      end
    end
    fetch_check(LIMIT_PC, 1'b0);
    finish_test("prefetch_limit", err0);
  endtask

  task automatic test_jump_flush();
    int unsigned err0;
    err0 = error_cnt;
    // free one slot, then jump while that line is in flight
    pc = LIMIT_PC + 16;
    @(negedge clk);
    while (!(r_ready && !r_valid)) @(negedge clk);
    @(posedge clk);
    #1;
    jump_to(JUMP_PC);
    wait_requests(1);
    check_cnt++;
    if (req_log[0] !== {JUMP_PC[31:4], 4'h0}) begin
      report_mismatch("ar_addr_o", pc, req_log[0], {JUMP_PC[31:4], 4'h0});
    end
    for (int i = 0; i < 6; i++) begin
      fetch_check(JUMP_PC + 4 * i, 1'b0);
    end
    finish_test("jump_flush", err0);
  endtask

  task automatic test_error_line();
    int unsigned err0;
    addr_t       wpc;
    err0     = error_cnt;
    err_line = ERR_LINE;
    jump_to(ERR_LINE - 16);
    for (int i = 0; i < 12; i++) begin
      wpc = ERR_LINE - 16 + 4 * i;
      fetch_check(wpc, wpc[31:4] == ERR_LINE[31:4]);
    end
    finish_test("error_line", err0);
  endtask

  // ============================================================
  // main sequence and timeout
  // ============================================================

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b1;
    pc        = RESET_PC;
    jmp_flush = 1'b0;
    err_line  = '0;
    error_cnt = 0;
    check_cnt = 0;
    test_cnt  = 0;
    test_reset_first_fetch();
    test_sequential_stream();
    test_prefetch_limit();
    test_jump_flush();
    test_error_line();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- src.f
+incdir+design
design/fetch_types_pkg.sv
design/bus_types_pkg.sv
design/line_fill_ctrl.sv
design/line_queue.sv
design/inst_select.sv
design/fetch_buffer_top.sv
tb/icache_model.sv
tb/tb_fetch_buffer.sv

//--- run.sh
#!/bin/sh
# build and run the fetch buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_fetch_buffer -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_fetch_buffer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
